//--- include/icache_macros.svh
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// instruction cache geometry

// physical fetch address
`define ICACHE_ADDR_W 32

// 16 sets, 2 ways
`define ICACHE_SET_W 4
`define ICACHE_WAYS 2

// address minus set, quarter and byte offset
`define ICACHE_TAG_W 23

// one fetch word is a quarter line
`define ICACHE_QUARTER_W 64
`define ICACHE_LINE_W 256

`endif

//--- rtl/icache_pkg.sv
`include "icache_macros.svh"

package icache_pkg;

  // fetch address split as the cache sees it
  typedef struct packed {
    logic [`ICACHE_TAG_W-1:0] tag;
    logic [`ICACHE_SET_W-1:0] set;
    // selects the 64-bit word within the line
    logic [1:0]               quarter;
    logic [2:0]               offset;
  } icache_addr_t;

  // one tag ram entry
  typedef struct packed {
    logic                     valid;
    logic [`ICACHE_TAG_W-1:0] tag;
  } icache_tag_entry_t;

  // a cache line, filled in halves and read in quarters
  typedef union packed {
    logic [1:0][`ICACHE_LINE_W/2-1:0] halves;
    logic [`ICACHE_LINE_W/`ICACHE_QUARTER_W-1:0][`ICACHE_QUARTER_W-1:0] quarters;
  } icache_line_u;

endpackage

//--- rtl/icache_ifs.sv
`timescale 1ns/100ps
`include "icache_macros.svh"

// core <-> tag array
interface icache_tag_if;
  logic                     lookup_en;
  icache_pkg::icache_addr_t lookup_addr;
  logic                     hit;
  logic                     hit_way;
  logic                     chk_en;
  icache_pkg::icache_addr_t chk_addr;
  logic                     chk_hit;
  // shared by refill and invalidate
  logic                     fill_en;
  icache_pkg::icache_addr_t fill_addr;
  logic                     fill_way;
  logic                     inval_en;
  logic                     evict_valid;
  icache_pkg::icache_addr_t evict_addr;

  modport core (
    output lookup_en, lookup_addr, chk_en, chk_addr, fill_en, fill_addr, inval_en,
    input  hit, hit_way, chk_hit, fill_way, evict_valid, evict_addr
  );

  modport tags (
    input  lookup_en, lookup_addr, chk_en, chk_addr, fill_en, fill_addr, inval_en,
    output hit, hit_way, chk_hit, fill_way, evict_valid, evict_addr
  );
endinterface

// core <-> line storage
interface icache_data_if;
  logic                     rd_en;
  logic [`ICACHE_SET_W-1:0] rd_set;
  icache_pkg::icache_line_u rd_line0;
  icache_pkg::icache_line_u rd_line1;
  logic                     wr_en;
  logic [`ICACHE_SET_W-1:0] wr_set;
  logic                     wr_way;
  icache_pkg::icache_line_u wr_line;

  modport core (output rd_en, rd_set, wr_en, wr_set, wr_way, wr_line, input rd_line0, rd_line1);
  modport data (input rd_en, rd_set, wr_en, wr_set, wr_way, wr_line, output rd_line0, rd_line1);
endinterface

//--- rtl/icache_stall_hold.sv
`timescale 1ns/100ps

module icache_stall_hold #(
  parameter int WIDTH = 1
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             fstall,
  input  logic             except,
  input  logic [WIDTH-1:0] d,
  output logic [WIDTH-1:0] q
);

  // flush beats stall
  always_ff @(posedge clk) begin
    if (rst || except) begin
      q <= '0;
    end else if (!fstall) begin
      q <= d;
    end
  end

endmodule

//--- rtl/icache_tag_array.sv
`timescale 1ns/100ps
`include "icache_macros.svh"

module icache_tag_array (
  input logic        clk,
  input logic        rst,
  icache_tag_if.tags tags
);

  localparam int SETS = 1 << `ICACHE_SET_W;

  icache_pkg::icache_tag_entry_t tag_mem [SETS][`ICACHE_WAYS];
  // per set, the way to replace next
  logic [SETS-1:0] lru;

  logic [`ICACHE_WAYS-1:0] look_match;
  logic [`ICACHE_WAYS-1:0] chk_match;
  logic [`ICACHE_WAYS-1:0] fill_match;
  logic fill_way;
  icache_pkg::icache_tag_entry_t victim;

  always_comb begin
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      look_match[w] = tag_mem[tags.lookup_addr.set][w].valid &&
                      tag_mem[tags.lookup_addr.set][w].tag == tags.lookup_addr.tag;
      chk_match[w]  = tag_mem[tags.chk_addr.set][w].valid &&
                      tag_mem[tags.chk_addr.set][w].tag == tags.chk_addr.tag;
      fill_match[w] = tag_mem[tags.fill_addr.set][w].valid &&
                      tag_mem[tags.fill_addr.set][w].tag == tags.fill_addr.tag;
    end
  end

  // refill of a present line reuses its way, else first free way, else lru
  always_comb begin
    if (|fill_match) begin
      fill_way = fill_match[1];
    end else if (!tag_mem[tags.fill_addr.set][0].valid) begin
      fill_way = 1'b0;
    end else if (!tag_mem[tags.fill_addr.set][1].valid) begin
      fill_way = 1'b1;
    end else begin
      fill_way = lru[tags.fill_addr.set];
    end
    victim = tag_mem[tags.fill_addr.set][fill_way];
  end

  assign tags.fill_way = fill_way;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < SETS; s++) begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
          tag_mem[s][w] <= '0;
        end
      end
      lru              <= '0;
      tags.hit         <= 1'b0;
      tags.hit_way     <= 1'b0;
      tags.chk_hit     <= 1'b0;
      tags.evict_valid <= 1'b0;
    end else begin
      // result held while the read pipeline is stalled
      if (tags.lookup_en) begin
        tags.hit     <= |look_match;
        tags.hit_way <= look_match[1];
        if (|look_match) begin
          lru[tags.lookup_addr.set] <= ~look_match[1];
        end
      end
      tags.chk_hit     <= tags.chk_en & (|chk_match);
      tags.evict_valid <= tags.fill_en & ~(|fill_match) & victim.valid;
      if (tags.fill_en) begin
        tag_mem[tags.fill_addr.set][fill_way] <= '{valid: 1'b1, tag: tags.fill_addr.tag};
        lru[tags.fill_addr.set] <= ~fill_way;
      end else if (tags.inval_en) begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
          if (fill_match[w]) begin
            tag_mem[tags.fill_addr.set][w].valid <= 1'b0;
          end
        end
      end
    end
  end

  // line address of the displaced way
  always_ff @(posedge clk) begin
    if (tags.fill_en) begin
      tags.evict_addr <= '{tag: victim.tag, set: tags.fill_addr.set, quarter: 2'b0, offset: 3'b0};
    end
  end

endmodule

//--- rtl/icache_data_array.sv
`timescale 1ns/100ps
`include "icache_macros.svh"

module icache_data_array (
  input logic         clk,
  icache_data_if.data data
);

  localparam int SETS = 1 << `ICACHE_SET_W;

  icache_pkg::icache_line_u line_mem [SETS][`ICACHE_WAYS];

  // full line write from the refill assembly
  always_ff @(posedge clk) begin
    if (data.wr_en) begin
      line_mem[data.wr_set][data.wr_way] <= data.wr_line;
    end
  end

  // both ways read out, the core picks one after the tag compare
  always_ff @(posedge clk) begin
    if (data.rd_en) begin
      data.rd_line0 <= line_mem[data.rd_set][0];
      data.rd_line1 <= line_mem[data.rd_set][1];
    end
  end

endmodule

//--- rtl/icache_core.sv
`timescale 1ns/100ps
`include "icache_macros.svh"

module icache_core (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          read_en,
  input  logic [`ICACHE_ADDR_W-1:0]     read_addr,
  input  logic                          fstall,
  input  logic                          except,
  input  logic                          write_en,
  input  logic [`ICACHE_ADDR_W-1:0]     write_addr,
  input  logic [`ICACHE_LINE_W/2-1:0]   write_data,
  input  logic                          invalidate,
  input  logic                          chk_en,
  input  logic [`ICACHE_ADDR_W-1:0]     chk_addr,
  output logic                          read_hit,
  output logic [`ICACHE_QUARTER_W-1:0]  read_data,
  output logic                          chk_hit,
  output logic                          evict_valid,
  output logic [`ICACHE_ADDR_W-1:0]     evict_addr,
  icache_tag_if.core                    tag,
  icache_data_if.core                   data
);

  // read pipeline
  logic                         rd_v1;
  icache_pkg::icache_addr_t     rd_addr1;
  logic                         rd_v2;
  logic [1:0]                   rd_quarter2;
  logic                         hit3;
  logic [`ICACHE_QUARTER_W-1:0] data3;
  icache_pkg::icache_line_u     sel_line;
  logic                         ev_v3;
  icache_pkg::icache_addr_t     ev_addr3;

  // probe, invalidate and refill requests
  logic                         chk_q;
  icache_pkg::icache_addr_t     chk_addr_q;
  logic                         inv_q;
  icache_pkg::icache_addr_t     inv_addr_q;
  logic [1:0]                   wen_step;
  icache_pkg::icache_addr_t     refill_addr;
  icache_pkg::icache_line_u     fill_line;

  // a flushed request must not touch the lru bits
  assign tag.lookup_en   = rd_v1 & ~fstall & ~except;
  assign tag.lookup_addr = rd_addr1;
  assign tag.chk_en      = chk_q;
  assign tag.chk_addr    = chk_addr_q;
  assign tag.fill_en     = wen_step[1];
  assign tag.fill_addr   = wen_step[1] ? refill_addr : inv_addr_q;
  assign tag.inval_en    = inv_q;

  assign data.rd_en   = tag.lookup_en;
  assign data.rd_set  = rd_addr1.set;
  assign data.wr_en   = wen_step[1];
  assign data.wr_set  = refill_addr.set;
  assign data.wr_way  = tag.fill_way;
  assign data.wr_line = fill_line;

  assign sel_line = tag.hit_way ? data.rd_line1 : data.rd_line0;

  always_ff @(posedge clk) begin
    if (rst || except) begin
      rd_v1 <= 1'b0;
      rd_v2 <= 1'b0;
      hit3  <= 1'b0;
      data3 <= '0;
      ev_v3 <= 1'b0;
    end else if (!fstall) begin
      rd_v1 <= read_en;
      rd_v2 <= rd_v1;
      hit3  <= rd_v2 & tag.hit;
      // zero data on a miss
      data3 <= (rd_v2 && tag.hit) ? sel_line.quarters[rd_quarter2] : '0;
      ev_v3 <= tag.evict_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!fstall) begin
      rd_addr1    <= read_addr;
      rd_quarter2 <= rd_addr1.quarter;
      ev_addr3    <= tag.evict_addr;
    end
  end

  // refill and probe run regardless of fstall
  always_ff @(posedge clk) begin
    if (rst) begin
      wen_step <= 2'b0;
      chk_q    <= 1'b0;
      chk_hit  <= 1'b0;
      inv_q    <= 1'b0;
    end else begin
      wen_step <= {wen_step[0], write_en};
      chk_q    <= chk_en;
      chk_hit  <= tag.chk_hit;
      inv_q    <= invalidate;
    end
  end

  always_ff @(posedge clk) begin
    chk_addr_q <= chk_addr;
    if (invalidate) begin
      inv_addr_q <= write_addr;
    end
    // low half with the request, upper half one cycle later
    if (write_en) begin
      refill_addr         <= write_addr;
      fill_line.halves[0] <= write_data;
    end
    if (wen_step[0]) begin
      fill_line.halves[1] <= write_data;
    end
  end

  icache_stall_hold #(.WIDTH(`ICACHE_QUARTER_W + 1)) read_hold_inst (
    .clk    (clk),
    .rst    (rst),
    .fstall (fstall),
    .except (except),
    .d      ({hit3, data3}),
    .q      ({read_hit, read_data})
  );

  icache_stall_hold #(.WIDTH(`ICACHE_ADDR_W + 1)) evict_hold_inst (
    .clk    (clk),
    .rst    (rst),
    .fstall (fstall),
    .except (except),
    .d      ({ev_v3, ev_addr3}),
    .q      ({evict_valid, evict_addr})
  );

endmodule

//--- rtl/icache_top.sv
`timescale 1ns/100ps
`include "icache_macros.svh"

module icache_top (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          read_en,
  input  logic [`ICACHE_ADDR_W-1:0]     read_addr,
  input  logic                          fstall,
  input  logic                          except,
  input  logic                          write_en,
  input  logic [`ICACHE_ADDR_W-1:0]     write_addr,
  input  logic [`ICACHE_LINE_W/2-1:0]   write_data,
  input  logic                          invalidate,
  input  logic                          chk_en,
  input  logic [`ICACHE_ADDR_W-1:0]     chk_addr,
  output logic                          read_hit,
  output logic [`ICACHE_QUARTER_W-1:0]  read_data,
  output logic                          chk_hit,
  output logic                          evict_valid,
  output logic [`ICACHE_ADDR_W-1:0]     evict_addr
);

  icache_tag_if  tag_if ();
  icache_data_if data_if ();

  icache_core core_inst (
    .clk         (clk),
    .rst         (rst),
    .read_en     (read_en),
    .read_addr   (read_addr),
    .fstall      (fstall),
    .except      (except),
    .write_en    (write_en),
    .write_addr  (write_addr),
    .write_data  (write_data),
    .invalidate  (invalidate),
    .chk_en      (chk_en),
    .chk_addr    (chk_addr),
    .read_hit    (read_hit),
    .read_data   (read_data),
    .chk_hit     (chk_hit),
    .evict_valid (evict_valid),
    .evict_addr  (evict_addr),
    .tag         (tag_if.core),
    .data        (data_if.core)
  );

  icache_tag_array tag_array_inst (
    .clk  (clk),
    .rst  (rst),
    .tags (tag_if.tags)
  );

  icache_data_array data_array_inst (
    .clk  (clk),
    .data (data_if.data)
  );

endmodule

//--- testbench/icache_tb.sv
`timescale 1ns/100ps

module icache_tb;

  // cycles per test in run order, plus reset and slack
  localparam int TEST_CYCLES     = 26 + 97 + 72 + 66 + 106;
  localparam int WATCHDOG_CYCLES = 5 + TEST_CYCLES + 100;

  logic         clk = 1'b0;
  logic         rst;
  logic         read_en;
  logic [31:0]  read_addr;
  logic         fstall;
  logic         except;
  logic         write_en;
  logic [31:0]  write_addr;
  logic [127:0] write_data;
  logic         invalidate;
  logic         chk_en;
  logic [31:0]  chk_addr;
  logic         read_hit;
  logic [63:0]  read_data;
  logic         chk_hit;
  logic         evict_valid;
  logic [31:0]  evict_addr;

  // reference model state
  logic [22:0]  m_tag [16][2];
  logic [1:0]   m_val [16];
  logic [15:0]  m_lru;
  logic [255:0] m_line [16][2];
  // read pipeline: request, looked up, selected, held
  logic [3:0]   rp_v;
  logic [31:0]  rp_a;
  logic [63:0]  rp_d [1:3];
  logic [2:0]   ev_v;
  logic [31:0]  ev_a [3];
  logic [1:0]   wst;
  logic [31:0]  w_addr;
  logic [127:0] w_lo;
  logic [127:0] w_hi;
  logic         inv_p;
  logic [31:0]  inv_a;
  logic [2:0]   ck;
  logic [31:0]  ck_a;

  logic [31:0]  lfsr = 32'hc068_41b3;
  logic [31:0]  recent [4];
  logic [1:0]   fill_ptr = 2'd0;
  logic [31:0]  last_fill;
  logic [31:0]  inv_addr;
  int           checks = 0;
  int           errors = 0;
  int           test_errors = 0;

  icache_top icache_top_inst (.*);

  always #5 clk = ~clk;

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
      r = {r[62:0], lfsr[0]};
    end
    return r;
  endfunction

  // 8 tags over sets 0..3, so sets fill up quickly
  function automatic logic [31:0] rand_addr();
    logic [63:0] r;
    r = rand_bits(10);
    return {20'h4c01d, r[9:7], 2'b00, r[6:5], r[4:0]};
  endfunction

  // half the time a recently refilled line
  function automatic logic [31:0] pick_addr();
    logic [63:0] r;
    r = rand_bits(8);
    if (r[7]) begin
      return {recent[r[6:5]][31:5], r[4:0]};
    end
    return rand_addr();
  endfunction

  function automatic logic present(input logic [31:0] a, output logic way);
    present = 1'b0;
    way = 1'b0;
    for (int w = 0; w < 2; w++) begin
      if (m_val[a[8:5]][w] && m_tag[a[8:5]][w] == a[31:9]) begin
        present = 1'b1;
        way = w[0];
      end
    end
  endfunction

  task automatic model_step();
    logic        rd_way;
    logic        rd_hit;
    logic        fill_way;
    logic        fill_hit;
    logic        inv_way;
    logic        inv_hit;
    logic        ck_way;
    logic        ck_res;
    logic        evict;
    logic [3:0]  fs;
    logic [63:0] rd_word;
    logic [31:0] ev_new;
    if (rst) begin
      for (int s = 0; s < 16; s++) begin
        m_val[s] = 2'b00;
      end
      m_lru = '0;
      rp_v = '0;
      ev_v = '0;
      wst = '0;
      inv_p = 1'b0;
      ck = '0;
      return;
    end
    // everything below the results uses the state before this edge
    ck_res = present(ck_a, ck_way) & ck[0];
    rd_hit = present(rp_a, rd_way) & rp_v[0] & !fstall & !except;
    rd_word = rd_hit ? m_line[rp_a[8:5]][rd_way][{rp_a[4:3], 6'b0} +: 64] : 64'h0;
    fs = w_addr[8:5];
    fill_hit = present(w_addr, fill_way);
    if (!fill_hit) begin
      fill_way = !m_val[fs][0] ? 1'b0 : (!m_val[fs][1] ? 1'b1 : m_lru[fs]);
    end
    evict = wst[1] & !fill_hit & m_val[fs][fill_way];
    ev_new = {m_tag[fs][fill_way], fs, 5'b0};
    inv_hit = present(inv_a, inv_way);
    if (rd_hit) begin
      m_lru[rp_a[8:5]] = !rd_way;
    end
    if (wst[1]) begin
      m_tag[fs][fill_way] = w_addr[31:9];
      m_val[fs][fill_way] = 1'b1;
      m_line[fs][fill_way] = {w_hi, w_lo};
      m_lru[fs] = !fill_way;
    end else if (inv_p && inv_hit) begin
      m_val[inv_a[8:5]][inv_way] = 1'b0;
    end
    if (except) begin
      rp_v = '0;
      ev_v[2:1] = 2'b00;
    end else if (!fstall) begin
      rp_v = {rp_v[2:1], rd_hit, read_en};
      rp_d[3] = rp_d[2];
      rp_d[2] = rp_d[1];
      rp_d[1] = rd_word;
      rp_a = read_addr;
      ev_v[2:1] = ev_v[1:0];
      ev_a[2] = ev_a[1];
      ev_a[1] = ev_a[0];
    end
    ev_v[0] = evict;
    if (wst[1]) begin
      ev_a[0] = ev_new;
    end
    if (wst[0]) begin
      w_hi = write_data;
    end
    wst = {wst[0], write_en};
    if (write_en) begin
      w_addr = write_addr;
      w_lo = write_data;
    end
    inv_p = invalidate;
    if (invalidate) begin
      inv_a = write_addr;
    end
    ck = {ck[1], ck_res, chk_en};
    ck_a = chk_addr;
  endtask

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("CHECK FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  always @(posedge clk) begin
    model_step();
  end

  // outputs settle after the rising edge, so sample at the falling edge
  always @(negedge clk) begin
    if (!rst) begin
      compare("read_hit", 64'(read_hit), 64'(rp_v[3]));
      compare("read_data", read_data, rp_v[3] ? rp_d[3] : 64'h0);
      compare("chk_hit", 64'(chk_hit), 64'(ck[2]));
      compare("evict_valid", 64'(evict_valid), 64'(ev_v[2]));
      if (ev_v[2]) begin
        compare("evict_addr", 64'(evict_addr), 64'(ev_a[2]));
      end
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    read_en    <= 1'b0;
    fstall     <= 1'b0;
    except     <= 1'b0;
    write_en   <= 1'b0;
    invalidate <= 1'b0;
    chk_en     <= 1'b0;
  endtask

  // low half with the request, upper half on the next cycle
  task automatic refill(input logic [31:0] addr);
    next_cycle();
    write_en   <= 1'b1;
    write_addr <= addr;
    write_data <= {rand_bits(64), rand_bits(64)};
    next_cycle();
    write_data <= {rand_bits(64), rand_bits(64)};
    recent[fill_ptr] = addr;
    fill_ptr = fill_ptr + 2'd1;
    last_fill = addr;
  endtask

  task automatic report_test(input string name);
    repeat (6) next_cycle();
    $display("%-26s %0d mismatches", name, test_errors);
    test_errors = 0;
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

  initial begin
    rst        = 1'b1;
    read_en    = 1'b0;
    read_addr  = '0;
    fstall     = 1'b0;
    except     = 1'b0;
    write_en   = 1'b0;
    write_addr = '0;
    write_data = '0;
    invalidate = 1'b0;
    chk_en     = 1'b0;
    chk_addr   = '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    for (int i = 0; i < 20; i++) begin
      next_cycle();
      read_en   <= 1'b1;
      read_addr <= rand_addr();
      chk_en    <= rand_bits(1) != 0;
      chk_addr  <= rand_addr();
    end
    report_test("empty cache after reset");

    for (int i = 0; i < 24; i++) begin
      refill(rand_addr());
    end
    repeat (3) next_cycle();
    for (int i = 0; i < 40; i++) begin
      next_cycle();
      read_en   <= 1'b1;
      read_addr <= pick_addr();
    end
    report_test("refill then read");

    // reads in between move the lru bits
    for (int i = 0; i < 20; i++) begin
      refill(rand_addr());
      next_cycle();
      read_en   <= 1'b1;
      read_addr <= pick_addr();
    end
    repeat (4) next_cycle();
    refill(last_fill);
    report_test("eviction on full sets");

    inv_addr = last_fill;
    for (int i = 0; i < 60; i++) begin
      next_cycle();
      if (rand_bits(1) != 0) begin
        inv_addr = pick_addr();
        invalidate <= 1'b1;
        write_addr <= inv_addr;
      end
      chk_en   <= 1'b1;
      chk_addr <= (rand_bits(1) != 0) ? inv_addr : pick_addr();
    end
    report_test("invalidate and probe");

    for (int i = 0; i < 80; i++) begin
      next_cycle();
      read_en   <= rand_bits(1) != 0;
      read_addr <= pick_addr();
      fstall    <= rand_bits(2) == 0;
      except    <= rand_bits(3) == 0;
      // a refill every fourth cycle keeps evictions in flight
      if (i % 4 == 0) begin
        write_en   <= 1'b1;
        write_addr <= rand_addr();
      end
      write_data <= {rand_bits(64), rand_bits(64)};
    end
    for (int i = 0; i < 20; i++) begin
      next_cycle();
      read_en   <= 1'b1;
      read_addr <= pick_addr();
    end
    report_test("stall and exception");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+include
rtl/icache_pkg.sv
rtl/icache_ifs.sv
rtl/icache_stall_hold.sv
rtl/icache_tag_array.sv
rtl/icache_data_array.sv
rtl/icache_core.sv
rtl/icache_top.sv
testbench/icache_tb.sv
